//--- build.f
rtl/chitchat_pkg.sv
rtl/chitchat_status_pkg.sv
rtl/cc_payload_if.sv
rtl/cc_check_if.sv
rtl/crc16.sv
rtl/chitchat_tx.sv
rtl/chitchat_rx_decode.sv
rtl/chitchat_rx_monitor.sv
rtl/chitchat_top.sv
tb/chitchat_tb.sv

//--- tb/chitchat_tb.sv
// Chitchat loopback testbench
`timescale 1ns/10ps
`default_nettype none

module chitchat_tb;

   localparam int NUM_ROWS       = 26;
   localparam int FRAME_WORDS    = chitchat_pkg::CC_FRAME_WORDS;
   localparam int TIMEOUT_CYCLES = (NUM_ROWS + 4) * FRAME_WORDS * 2;

   // Channel damage applied to one frame
   typedef enum logic [1:0] {
      CORR_NONE,
      CORR_FLIP,       // XOR one slot with the CRC left stale
      CORR_FLIP_FIX,   // XOR one slot and rebuild W10 from the model
      CORR_NO_COMMA    // k dropped on W0
   } corr_e;

   typedef struct packed {
      logic [3:0]  protocol_ver;
      logic [2:0]  location;
      logic [31:0] rev_id;
      logic [31:0] data0;
      logic [31:0] data1;
      logic [15:0] loopback;
      corr_e       kind;
      logic [3:0]  slot;
      logic [15:0] mask;
      logic        exp_valid;
      logic        exp_drop;
      logic [2:0]  exp_fault;
      logic        exp_inc;
      logic        exp_los;
   } row_t;

   logic        clk;
   logic        rst_n;
   logic [3:0]  tx_protocol_ver;
   logic [2:0]  tx_gateware_type;
   logic [2:0]  tx_location;
   logic [31:0] tx_rev_id;
   logic [31:0] tx_data0;
   logic [31:0] tx_data1;
   logic [15:0] tx_loopback_frame_counter;
   logic [15:0] tx_gtx_d;
   logic        tx_gtx_k;
   logic [15:0] local_frame_counter;
   logic [15:0] rx_gtx_d;
   logic        rx_gtx_k;
   logic        rx_valid;
   logic [3:0]  rx_protocol_ver;
   logic [2:0]  rx_gateware_type;
   logic [2:0]  rx_location;
   logic [31:0] rx_rev_id;
   logic [31:0] rx_data0;
   logic [31:0] rx_data1;
   logic [15:0] rx_frame_counter;
   logic [15:0] rx_loopback_frame_counter;
   logic [2:0]  ccrx_fault;
   logic [15:0] ccrx_fault_cnt;
   logic        ccrx_los;
   logic        ccrx_frame_drop;

   row_t        rows [0:NUM_ROWS-1];
   int          nrows;
   integer      seed;
   int          cycle_cnt;
   logic [15:0] exp_fault_cnt;
   // Model CRC over the sent words and over the words put on the line
   logic [15:0] tx_crc;
   logic [15:0] line_crc;

   chitchat_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ------------------------------
   // Failure reporting
   // ------------------------------
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic field_compare(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      if (act !== exp) begin
         stop_with_failure($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                                     $time, name, exp, act));
      end
   endtask

   task automatic status_compare(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
      if (act !== exp) begin
         stop_with_failure($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                                     $time, name, exp, act));
      end
   endtask

   task automatic pulse_compare(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_with_failure($sformatf("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                                     $time, name, exp, act));
      end
   endtask

   // Timeout watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      wait (cycle_cnt == TIMEOUT_CYCLES);
      stop_with_failure($sformatf("Timeout: test still running after %0d cycles", cycle_cnt));
   end

   // ------------------------------
   // Reference CCITT CRC with MSB first
   // ------------------------------
   function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [15:0] w);
      logic [15:0] c;
      c = crc;
      for (int i = 15; i >= 0; i--) begin
         c = (c[15] ^ w[i]) ? ((c << 1) ^ chitchat_pkg::CC_CRC_POLY) : (c << 1);
      end
      return c;
   endfunction

   // ------------------------------
   // Stimulus table
   // ------------------------------
   task automatic add_row(input corr_e kind, input int slot, input logic [15:0] mask,
                          input logic v, input logic d, input logic [2:0] f, input logic los);
      row_t        row;
      logic [31:0] rnd;
      rnd              = $random(seed);
      row.protocol_ver = rnd[3:0];
      row.location     = rnd[6:4];
      row.loopback     = rnd[31:16];
      row.rev_id       = $random(seed);
      row.data0        = $random(seed);
      row.data1        = $random(seed);
      row.kind         = kind;
      row.slot         = 4'(slot);
      row.mask         = mask;
      row.exp_valid    = v;
      row.exp_drop     = d;
      row.exp_fault    = f;
      // Every fault row follows a trained link so each one counts
      row.exp_inc      = |f;
      row.exp_los      = los;
      rows[nrows]      = row;
      nrows++;
   endtask

   // Clean frames with the first few still in training
   task automatic clean_rows(input int count, input int drops);
      for (int i = 0; i < count; i++) begin
         add_row(CORR_NONE, 0, 16'h0, (i >= drops), (i < drops), 3'b000, 1'b0);
      end
   endtask

   task automatic build_table;
      nrows = 0;
      clean_rows(5, 3);
      // Data word hit with a stale CRC
      add_row(CORR_FLIP, 5, 16'h0001, 1'b0, 1'b1, 3'b010, 1'b0);
      clean_rows(4, 3);
      // Wrong gateware type with the CRC rebuilt
      add_row(CORR_FLIP_FIX, 1, 16'hE000, 1'b0, 1'b1, 3'b001, 1'b0);
      clean_rows(4, 3);
      // Frame counter replaced and the CRC rebuilt
      add_row(CORR_FLIP_FIX, 8, 16'h0100, 1'b0, 1'b1, 3'b100, 1'b0);
      clean_rows(4, 3);
      // Missing comma leaves no frame end at all
      add_row(CORR_NO_COMMA, 0, 16'h0, 1'b0, 1'b0, 3'b000, 1'b1);
      clean_rows(5, 3);
   endtask

   task automatic drive_payload(input int r);
      tx_protocol_ver           = rows[r].protocol_ver;
      tx_gateware_type          = chitchat_pkg::CC_GATEWARE_TYPE;
      tx_location               = rows[r].location;
      tx_rev_id                 = rows[r].rev_id;
      tx_data0                  = rows[r].data0;
      tx_data1                  = rows[r].data1;
      tx_loopback_frame_counter = rows[r].loopback;
   endtask

   // ------------------------------
   // Line with optional damage
   // ------------------------------
   task automatic forward_word(input int r, input int s);
      logic [15:0] w;
      logic        k;
      w = tx_gtx_d;
      k = tx_gtx_k;
      // Assembler CRC checked against the model first
      if (s == 0) begin
         tx_crc = crc_step(chitchat_pkg::CC_CRC_INIT, w);
      end else if (s < FRAME_WORDS - 1) begin
         tx_crc = crc_step(tx_crc, w);
      end else begin
         status_compare("tx_gtx_d", tx_crc, w);
      end
      if (rows[r].kind inside {CORR_FLIP, CORR_FLIP_FIX} && 4'(s) == rows[r].slot) begin
         w = w ^ rows[r].mask;
      end
      if (rows[r].kind == CORR_NO_COMMA && s == 0) begin
         k = 1'b0;
      end
      if (rows[r].kind == CORR_FLIP_FIX && s == FRAME_WORDS - 1) begin
         w = line_crc;
      end
      if (s == 0) begin
         line_crc = crc_step(chitchat_pkg::CC_CRC_INIT, w);
      end else if (s < FRAME_WORDS - 1) begin
         line_crc = crc_step(line_crc, w);
      end
      rx_gtx_d = w;
      rx_gtx_k = k;
   endtask

   // Outputs on the clock after a frame's W10
   task automatic verify_decision(input int r);
      pulse_compare("rx_valid", rows[r].exp_valid, rx_valid);
      pulse_compare("ccrx_frame_drop", rows[r].exp_drop, ccrx_frame_drop);
      pulse_compare("ccrx_los", rows[r].exp_los, ccrx_los);
      status_compare("ccrx_fault", 16'(rows[r].exp_fault), 16'(ccrx_fault));
      if (rows[r].exp_inc) begin
         exp_fault_cnt = exp_fault_cnt + 16'd1;
      end
      status_compare("ccrx_fault_cnt", exp_fault_cnt, ccrx_fault_cnt);
      if (rows[r].exp_valid) begin
         field_compare("rx_protocol_ver", 32'(rows[r].protocol_ver), 32'(rx_protocol_ver));
         field_compare("rx_gateware_type", 32'(chitchat_pkg::CC_GATEWARE_TYPE),
                       32'(rx_gateware_type));
         field_compare("rx_location", 32'(rows[r].location), 32'(rx_location));
         field_compare("rx_rev_id", rows[r].rev_id, rx_rev_id);
         field_compare("rx_data0", rows[r].data0, rx_data0);
         field_compare("rx_data1", rows[r].data1, rx_data1);
         // Counter starts at zero and steps by one per frame
         field_compare("rx_frame_counter", 32'(r[15:0]), 32'(rx_frame_counter));
         field_compare("rx_loopback_frame_counter", 32'(rows[r].loopback),
                       32'(rx_loopback_frame_counter));
      end
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      seed          = 32'h54b3;
      cycle_cnt     = 0;
      exp_fault_cnt = '0;
      tx_crc        = '0;
      line_crc      = '0;
      build_table();
      rst_n    = 1'b0;
      rx_gtx_d = '0;
      rx_gtx_k = 1'b0;
      drive_payload(0);
      repeat (16) @(posedge clk);
      #2;
      pulse_compare("rx_valid", 1'b0, rx_valid);
      pulse_compare("ccrx_frame_drop", 1'b0, ccrx_frame_drop);
      pulse_compare("ccrx_los", 1'b0, ccrx_los);
      status_compare("ccrx_fault", 16'h0, 16'(ccrx_fault));
      status_compare("ccrx_fault_cnt", 16'h0, ccrx_fault_cnt);
      rst_n = 1'b1;
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int s = 0; s < FRAME_WORDS; s++) begin
            @(posedge clk);
            #2;
            // First W0 one cycle after reset and one comma per frame after that
            pulse_compare("tx_gtx_k", (s == 0), tx_gtx_k);
            // Local counter names the frame on the line up to its CRC word
            if (s < FRAME_WORDS - 1) begin
               status_compare("local_frame_counter", 16'(r), local_frame_counter);
            end
            if (s == 0 && r > 0) begin
               verify_decision(r - 1);
            end else begin
               pulse_compare("rx_valid", 1'b0, rx_valid);
               pulse_compare("ccrx_frame_drop", 1'b0, ccrx_frame_drop);
            end
            // Assembler took this frame's payload at the edge just passed
            if (s == 0 && r + 1 < NUM_ROWS) begin
               drive_payload(r + 1);
            end
            forward_word(r, s);
         end
      end
      @(posedge clk);
      #2;
      verify_decision(NUM_ROWS - 1);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/chitchat_top.sv
// Chitchat link top level
`timescale 1ns/10ps
`default_nettype none

module chitchat_top (
   input  logic        clk,
   input  logic        rst_n,

   // Transmit application side
   input  logic [3:0]  tx_protocol_ver,
   input  logic [2:0]  tx_gateware_type,
   input  logic [2:0]  tx_location,
   input  logic [31:0] tx_rev_id,
   input  logic [31:0] tx_data0,
   input  logic [31:0] tx_data1,
   input  logic [15:0] tx_loopback_frame_counter,
   // Transmit line side
   output logic [15:0] tx_gtx_d,
   output logic        tx_gtx_k,
   output logic [15:0] local_frame_counter,

   // Receive line side
   input  logic [15:0] rx_gtx_d,
   input  logic        rx_gtx_k,
   // Receive application side
   output logic        rx_valid,
   output logic [3:0]  rx_protocol_ver,
   output logic [2:0]  rx_gateware_type,
   output logic [2:0]  rx_location,
   output logic [31:0] rx_rev_id,
   output logic [31:0] rx_data0,
   output logic [31:0] rx_data1,
   output logic [15:0] rx_frame_counter,
   output logic [15:0] rx_loopback_frame_counter,
   // Link status
   output logic [2:0]  ccrx_fault,
   output logic [15:0] ccrx_fault_cnt,
   output logic        ccrx_los,
   output logic        ccrx_frame_drop
);

   cc_payload_if tx_pay ();
   cc_payload_if rx_pay ();
   cc_check_if   chk ();

   // ------------------------------
   // Transmit path
   // ------------------------------
   assign tx_pay.protocol_ver           = tx_protocol_ver;
   assign tx_pay.gateware_type          = tx_gateware_type;
   assign tx_pay.location               = tx_location;
   assign tx_pay.rev_id                 = tx_rev_id;
   assign tx_pay.data0                  = tx_data0;
   assign tx_pay.data1                  = tx_data1;
   assign tx_pay.loopback_frame_counter = tx_loopback_frame_counter;
   // Counter comes from the assembler itself
   assign tx_pay.frame_counter          = local_frame_counter;

   chitchat_tx u_tx (
      .clk                 (clk),
      .rst_n               (rst_n),
      .pay                 (tx_pay.dst),
      .gtx_d               (tx_gtx_d),
      .gtx_k               (tx_gtx_k),
      .local_frame_counter (local_frame_counter)
   );

   // ------------------------------
   // Receive path
   // ------------------------------
   chitchat_rx_decode u_dec (
      .clk   (clk),
      .rst_n (rst_n),
      .gtx_d (rx_gtx_d),
      .gtx_k (rx_gtx_k),
      .pay   (rx_pay.src),
      .chk   (chk.dec)
   );

   chitchat_rx_monitor u_mon (
      .clk             (clk),
      .rst_n           (rst_n),
      .chk             (chk.mon),
      .rx_valid        (rx_valid),
      .ccrx_frame_drop (ccrx_frame_drop),
      .ccrx_los        (ccrx_los),
      .ccrx_fault      (ccrx_fault),
      .ccrx_fault_cnt  (ccrx_fault_cnt)
   );

   assign rx_protocol_ver           = rx_pay.protocol_ver;
   assign rx_gateware_type          = rx_pay.gateware_type;
   assign rx_location               = rx_pay.location;
   assign rx_rev_id                 = rx_pay.rev_id;
   assign rx_data0                  = rx_pay.data0;
   assign rx_data1                  = rx_pay.data1;
   assign rx_frame_counter          = rx_pay.frame_counter;
   assign rx_loopback_frame_counter = rx_pay.loopback_frame_counter;

endmodule

`default_nettype wire

//--- rtl/chitchat_rx_monitor.sv
// Chitchat link monitor
`timescale 1ns/10ps
`default_nettype none

module chitchat_rx_monitor (
   input  logic        clk,
   input  logic        rst_n,
   cc_check_if.mon     chk,
   output logic        rx_valid,
   output logic        ccrx_frame_drop,
   output logic        ccrx_los,
   output logic [2:0]  ccrx_fault,
   output logic [15:0] ccrx_fault_cnt
);

   chitchat_status_pkg::link_state_e state;
   logic [$clog2(chitchat_status_pkg::LINK_UP_CNT + 1)-1:0] good_cnt;
   logic frame_bad;
   logic frame_good;
   logic link_up;

   assign frame_bad  = chk.last & (|chk.faults);
   assign frame_good = chk.last & ~(|chk.faults);
   assign link_up    = (state == chitchat_status_pkg::LINK_UP);

   // Latched fault or lost sync leaves no counter to trust
   assign chk.prev_bad = (|ccrx_fault) | ccrx_los;

   // ------------------------------
   // Link state
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= chitchat_status_pkg::LINK_DOWN;
         good_cnt <= '0;
      end else if (chk.timeout | frame_bad) begin
         state    <= chitchat_status_pkg::LINK_DOWN;
         good_cnt <= '0;
      end else if (frame_good && !link_up) begin
         good_cnt <= good_cnt + 1'b1;
         if (good_cnt + 1 == chitchat_status_pkg::LINK_UP_CNT) begin
            state <= chitchat_status_pkg::LINK_UP;
         end else begin
            state <= chitchat_status_pkg::LINK_TRAIN;
         end
      end
   end

   // ------------------------------
   // Frame decision and status
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_valid        <= 1'b0;
         ccrx_frame_drop <= 1'b0;
         ccrx_los        <= 1'b0;
         ccrx_fault      <= '0;
         ccrx_fault_cnt  <= '0;
      end else begin
         rx_valid        <= frame_good & link_up;
         // Bad frames and training frames are both dropped
         ccrx_frame_drop <= frame_bad | (frame_good & ~link_up);
         if (chk.last | chk.timeout) begin
            ccrx_los <= chk.timeout;
         end
         // Faults only count once some good frame was seen
         if (frame_bad && state != chitchat_status_pkg::LINK_DOWN) begin
            ccrx_fault     <= chk.faults;
            ccrx_fault_cnt <= ccrx_fault_cnt + 16'd1;
         end else if (frame_good) begin
            ccrx_fault <= '0;
         end
      end
   end

   // One decision per frame end, never both pulses
   a_one_decision : assert property (
      @(posedge clk) disable iff (!rst_n)
      (rx_valid | ccrx_frame_drop) |-> (rx_valid ^ ccrx_frame_drop) && $past(chk.last)
   );

endmodule

`default_nettype wire

//--- rtl/chitchat_rx_decode.sv
// Chitchat receive decoder
`timescale 1ns/10ps
`default_nettype none

module chitchat_rx_decode (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] gtx_d,
   input  logic        gtx_k,
   cc_payload_if.src   pay,
   cc_check_if.dec     chk
);

   logic [3:0]  word_count;
   logic [3:0]  slot_now;
   logic [15:0] gtx_dd;
   logic [15:0] crc;
   logic [15:0] remainder;
   logic [15:0] expect_cnt;
   logic        wrong_prot;
   logic        wrong_frame;
   logic        crc_fault;

   // ------------------------------
   // Word timer
   // ------------------------------
   // Zero on the word after the comma, parks at the timeout count
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         word_count <= '0;
      end else if (gtx_k) begin
         word_count <= '0;
      end else if (!chk.timeout) begin
         word_count <= word_count + 4'd1;
      end
   end

   assign chk.timeout = (word_count == 4'(chitchat_pkg::CC_TIMEOUT_WORDS));

   // Slot of the word now on gtx_d
   assign slot_now = word_count + 4'd1;
   assign chk.last = (slot_now == chitchat_pkg::W10);

   // ------------------------------
   // CRC check
   // ------------------------------
   crc16 u_crc (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (gtx_k),
      .din   (gtx_d),
      .crc   (crc)
   );

   // Folding a word equal to the register clears it
   // so the remainder after W10 is just this XOR
   assign remainder = crc ^ gtx_d;
   assign crc_fault = chk.last & (|remainder);

   // ------------------------------
   // Header and sequence checks
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wrong_prot  <= 1'b0;
         wrong_frame <= 1'b0;
         // First frame after reset carries counter zero
         expect_cnt  <= '0;
      end else begin
         if (slot_now == chitchat_pkg::W1) begin
            // W0 is in the delay register by now
            wrong_prot <= (gtx_dd[15:12] != chitchat_pkg::CC_PROTOCOL_CAT) |
                          (gtx_d[15:13] != chitchat_pkg::CC_GATEWARE_TYPE);
         end
         if (slot_now == chitchat_pkg::W8) begin
            expect_cnt  <= gtx_d + 16'd1;
            // No trusted reference after a bad frame
            wrong_frame <= !chk.prev_bad && (gtx_d != expect_cnt);
         end
      end
   end

   always_comb begin
      chk.faults = '0;
      chk.faults[chitchat_status_pkg::FAULT_PROT]  = wrong_prot;
      chk.faults[chitchat_status_pkg::FAULT_CRC]   = crc_fault;
      chk.faults[chitchat_status_pkg::FAULT_FRAME] = wrong_frame;
   end

   // ------------------------------
   // Field unpacking
   // ------------------------------
   always_ff @(posedge clk) begin
      gtx_dd <= gtx_d;
      case (slot_now)
         chitchat_pkg::W1: begin
            pay.protocol_ver  <= gtx_dd[11:8];
            pay.gateware_type <= gtx_d[15:13];
            pay.location      <= gtx_d[12:10];
         end
         chitchat_pkg::W3: pay.rev_id                 <= {gtx_dd, gtx_d};
         chitchat_pkg::W5: pay.data0                  <= {gtx_dd, gtx_d};
         chitchat_pkg::W7: pay.data1                  <= {gtx_dd, gtx_d};
         chitchat_pkg::W8: pay.frame_counter          <= gtx_d;
         chitchat_pkg::W9: pay.loopback_frame_counter <= gtx_d;
         default: ;
      endcase
   end

   // A comma where the CRC word belongs means a short frame
   a_last_no_comma : assert property (
      @(posedge clk) disable iff (!rst_n) chk.last |-> !gtx_k
   );

endmodule

`default_nettype wire

//--- rtl/chitchat_tx.sv
// Chitchat frame assembler
`timescale 1ns/10ps
`default_nettype none

module chitchat_tx (
   input  logic        clk,
   input  logic        rst_n,
   cc_payload_if.dst   pay,
   output logic [15:0] gtx_d,
   output logic        gtx_k,
   output logic [15:0] local_frame_counter
);

   chitchat_pkg::cc_slot_e slot;
   logic [15:0] word;
   logic [15:0] crc;
   logic        frame_start;
   logic        frame_end;
   logic [15:0] frame_cnt;

   // Payload held for the rest of the frame
   logic [2:0]  gateware_type_q;
   logic [2:0]  location_q;
   logic [31:0] rev_id_q;
   logic [31:0] data0_q;
   logic [31:0] data1_q;
   logic [15:0] loopback_q;

   assign frame_start = (slot == chitchat_pkg::W0);
   assign frame_end   = (slot == chitchat_pkg::cc_slot_e'(chitchat_pkg::CC_FRAME_WORDS - 1));

   // ------------------------------
   // Slot sequencer and counters
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot      <= chitchat_pkg::W0;
         frame_cnt <= '0;
      end else if (frame_end) begin
         slot      <= chitchat_pkg::W0;
         // Wraps at 16 bits
         frame_cnt <= frame_cnt + 16'd1;
      end else begin
         slot <= chitchat_pkg::cc_slot_e'(slot + 4'd1);
      end
   end

   assign local_frame_counter = frame_cnt;

   // Snapshot taken while W0 goes out
   always_ff @(posedge clk) begin
      if (frame_start) begin
         gateware_type_q <= pay.gateware_type;
         location_q      <= pay.location;
         rev_id_q        <= pay.rev_id;
         data0_q         <= pay.data0;
         data1_q         <= pay.data1;
         loopback_q      <= pay.loopback_frame_counter;
      end
   end

   // ------------------------------
   // Word multiplexer
   // ------------------------------
   always_comb begin
      case (slot)
         chitchat_pkg::W0: word = {chitchat_pkg::CC_PROTOCOL_CAT, pay.protocol_ver,
                                   chitchat_pkg::CC_COMMA};
         chitchat_pkg::W1: word = {gateware_type_q, location_q, 10'b0};
         chitchat_pkg::W2: word = rev_id_q[31:16];
         chitchat_pkg::W3: word = rev_id_q[15:0];
         chitchat_pkg::W4: word = data0_q[31:16];
         chitchat_pkg::W5: word = data0_q[15:0];
         chitchat_pkg::W6: word = data1_q[31:16];
         chitchat_pkg::W7: word = data1_q[15:0];
         chitchat_pkg::W8: word = frame_cnt;
         chitchat_pkg::W9: word = loopback_q;
         // W10 carries the CRC of W0 to W9
         default:          word = crc;
      endcase
   end

   // CRC restarts on the header word
   crc16 u_crc (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (frame_start),
      .din   (word),
      .crc   (crc)
   );

   // Registered line outputs
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gtx_d <= '0;
         gtx_k <= 1'b0;
      end else begin
         gtx_d <= word;
         gtx_k <= frame_start;
      end
   end

   // Comma on W0 only, one every frame length
   a_comma_period : assert property (
      @(posedge clk) disable iff (!rst_n)
      gtx_k |-> (gtx_d[7:0] == chitchat_pkg::CC_COMMA) ##1 !gtx_k [*10] ##1 gtx_k
   );

endmodule

`default_nettype wire

//--- rtl/crc16.sv
// CRC-16 word engine
`timescale 1ns/10ps
`default_nettype none

module crc16 (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               clear,
   input  logic [chitchat_pkg::CC_WORD_W-1:0] din,
   output logic [chitchat_pkg::CC_WORD_W-1:0] crc
);

   logic [chitchat_pkg::CC_WORD_W-1:0] acc;
   logic                               fb;

   // Bit serial CCITT update unrolled over one word
   // MSB of the word goes in first
   always_comb begin
      acc = clear ? chitchat_pkg::CC_CRC_INIT : crc;
      for (int i = chitchat_pkg::CC_WORD_W - 1; i >= 0; i--) begin
         fb  = acc[chitchat_pkg::CC_WORD_W-1] ^ din[i];
         acc = {acc[chitchat_pkg::CC_WORD_W-2:0], 1'b0};
         if (fb) begin
            acc = acc ^ chitchat_pkg::CC_CRC_POLY;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         crc <= chitchat_pkg::CC_CRC_INIT;
      end else begin
         crc <= acc;
      end
   end

   // Reload comes once per frame and never on two words in a row
   a_clear_spaced : assert property (
      @(posedge clk) disable iff (!rst_n) clear |=> !clear
   );

endmodule

`default_nettype wire

//--- rtl/cc_check_if.sv
// Chitchat frame check bundle
`timescale 1ns/10ps
`default_nettype none

interface cc_check_if;

   // Pulse while the CRC word of a frame is on the input
   logic last;
   // Word timer saturated, no comma seen for too long
   logic timeout;
   // Per-frame fault bits, only meaningful with last
   logic [chitchat_status_pkg::FAULT_W-1:0] faults;

   // Previous frame ended badly
   // so the decoder has no trusted counter to compare against
   logic prev_bad;

   // Decoder side
   modport dec (
      output last,
      output timeout,
      output faults,
      input  prev_bad
   );

   // Monitor side
   modport mon (
      input  last,
      input  timeout,
      input  faults,
      output prev_bad
   );

endinterface

`default_nettype wire

//--- rtl/cc_payload_if.sv
// Chitchat payload bundle
`timescale 1ns/10ps
`default_nettype none

interface cc_payload_if;

   // Header fields
   logic [3:0]  protocol_ver;
   logic [2:0]  gateware_type;
   logic [2:0]  location;

   // Application words
   logic [31:0] rev_id;
   logic [31:0] data0;
   logic [31:0] data1;

   // Counters, one word each
   logic [chitchat_pkg::CC_WORD_W-1:0] frame_counter;
   logic [chitchat_pkg::CC_WORD_W-1:0] loopback_frame_counter;

   // Producer side
   modport src (
      output protocol_ver, gateware_type, location,
      output rev_id, data0, data1,
      output frame_counter, loopback_frame_counter
   );

   // Consumer side
   modport dst (
      input protocol_ver, gateware_type, location,
      input rev_id, data0, data1,
      input frame_counter, loopback_frame_counter
   );

endinterface

`default_nettype wire

//--- rtl/chitchat_status_pkg.sv
// Chitchat link status
`default_nettype none

package chitchat_status_pkg;

   // ------------------------------
   // Fault vector layout
   // ------------------------------
   localparam int FAULT_W     = 3;
   // Wrong protocol category or gateware type
   localparam int FAULT_PROT  = 0;
   // CRC remainder not zero
   localparam int FAULT_CRC   = 1;
   // Frame counter out of sequence
   localparam int FAULT_FRAME = 2;

   // ------------------------------
   // Link training
   // ------------------------------
   // Consecutive good frames needed for link up
   localparam int LINK_UP_CNT = 3;

   typedef enum logic [1:0] {
      LINK_DOWN,
      LINK_TRAIN,
      LINK_UP
   } link_state_e;

endpackage

`default_nettype wire

//--- rtl/chitchat_pkg.sv
// Chitchat frame format
`default_nettype none

package chitchat_pkg;

   // ------------------------------
   // Stream geometry
   // ------------------------------

   // One transceiver word per clock
   localparam int CC_WORD_W = 16;
   // Frames run back to back with no idle words
   localparam int CC_FRAME_WORDS = 11;

   // K28.5 sits in the low byte of word 0 while k is high
   localparam logic [7:0] CC_COMMA = 8'hBC;

   // Header nibbles in word 0
   localparam logic [3:0] CC_PROTOCOL_CAT = 4'h1;
   localparam logic [3:0] CC_PROTOCOL_VER = 4'h1;

   // Gateware type the far end must report
   localparam logic [2:0] CC_GATEWARE_TYPE = 3'd1;

   // CCITT CRC, register preset to all ones
   localparam logic [CC_WORD_W-1:0] CC_CRC_INIT = '1;
   localparam logic [CC_WORD_W-1:0] CC_CRC_POLY = 16'h1021;

   // Words without a comma before sync counts as lost
   localparam int CC_TIMEOUT_WORDS = 15;

   // ------------------------------
   // Word slots within a frame
   // ------------------------------
   typedef enum logic [3:0] {
      W0  = 4'd0,   // Comma and header
      W1  = 4'd1,   // Gateware type, location, reserved
      W2  = 4'd2,   // rev_id high
      W3  = 4'd3,   // rev_id low
      W4  = 4'd4,   // data0 high
      W5  = 4'd5,   // data0 low
      W6  = 4'd6,   // data1 high
      W7  = 4'd7,   // data1 low
      W8  = 4'd8,   // Frame counter
      W9  = 4'd9,   // Loopback counter
      W10 = 4'd10   // CRC
   } cc_slot_e;

endpackage

`default_nettype wire
